// File: vlog.f
src/fp_pkg.sv
src/isqrt_pkg.sv
src/pipe_mult.sv
src/isqrt_classify.sv
src/isqrt_exponent.sv
src/newton_step.sv
src/isqrt_mantissa.sv
src/isqrt_round.sv
src/fp_inverse_sqrt.sv
test/isqrt_checker.sv
test/tb_fp_inverse_sqrt.sv

// File: test/tb_fp_inverse_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_inverse_sqrt;

    import fp_pkg::*;

    localparam int CLK_HALF = 2;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 8;
    localparam int LATENCY = 17;
    localparam int RANDOM_COUNT = 200;
    // upper bound on the operands driven over the whole run
    localparam int NUM_OPERANDS = 256;
    localparam logic [31:0] LFSR_SEED = 32'd96315;
    localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

    typedef struct packed {
        fp32_t       value;
        logic        approx;
        logic        invalid;
        logic        div_zero;
        logic        check_inexact;
        logic        inexact;
        logic [31:0] cycle;
    } expect_t;

    logic  clk;
    logic  rst;
    logic  valid_in;
    fp32_t operand;
    fp32_t result;
    logic  valid_out;
    logic  invalid_operation;
    logic  division_by_zero;
    logic  inexact;

    expect_t     expect_q [$];
    expect_t     popped;
    logic [31:0] lfsr_state;
    int          neg_count;
    int          checks;
    int          errors;
    int          total_errors;

    fp_inverse_sqrt uut (
        .clk               (clk),
        .rst               (rst),
        .valid_in          (valid_in),
        .operand           (operand),
        .result            (result),
        .valid_out         (valid_out),
        .invalid_operation (invalid_operation),
        .division_by_zero  (division_by_zero),
        .inexact           (inexact)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] take_random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    function automatic fp32_t random_normal();
        fp32_t v;
        v.sign = 1'b0;
        // exponents 100 to 163 keep operand and result far from the format limits
        v.exponent = fp_exp_t'(100 + take_random_bits(6));
        v.mantissa = fp_man_t'(take_random_bits(23));
        return v;
    endfunction

    function automatic real fp32_to_real(input fp32_t v);
        real r;
        int  e;
        r = v.mantissa;
        r = r + 8388608.0;
        e = int'(v.exponent) - 150;
        while (e > 0) begin
            r = r * 2.0;
            e--;
        end
        while (e < 0) begin
            r = r / 2.0;
            e++;
        end
        return r;
    endfunction

    // positive normal values only
    function automatic fp32_t real_to_fp32(input real r);
        fp32_t v;
        int    e;
        int    m;
        real   frac;
        e = 127;
        while (r >= 2.0) begin
            r = r / 2.0;
            e++;
        end
        while (r < 1.0) begin
            r = r * 2.0;
            e--;
        end
        frac = (r - 1.0) * 8388608.0;
        m = $rtoi(frac);
        // nearest, ties to even
        if (frac - m > 0.5 || (frac - m == 0.5 && m % 2 == 1)) begin
            m++;
        end
        if (m == 8388608) begin
            m = 0;
            e++;
        end
        v.sign = 1'b0;
        v.exponent = fp_exp_t'(e);
        v.mantissa = fp_man_t'(m);
        return v;
    endfunction

    function automatic expect_t expected_response(input fp32_t op);
        expect_t e;
        logic    is_nan;
        is_nan = (op.exponent == '1) && (op.mantissa != '0);
        e = '0;
        e.check_inexact = 1'b1;
        if (is_nan && op.mantissa[FP_QNAN_BIT]) begin
            e.value = op;
        end else if (is_nan) begin
            e.value = op;
            e.value.mantissa[FP_QNAN_BIT] = 1'b1;
            e.invalid = 1'b1;
        end else if (op.sign) begin
            e.value = FP_DEFAULT_NAN;
        end else if (op.exponent == '1) begin
            e.value = '0;
        end else if (op.exponent == '0) begin
            // positive zero or denormal
            e.value = FP_PLUS_INF;
            e.div_zero = 1'b1;
        end else begin
            e.value = real_to_fp32(1.0 / $sqrt(fp32_to_real(op)));
            e.approx = 1'b1;
            e.check_inexact = 1'b0;
        end
        return e;
    endfunction

    function automatic longint ulp_distance(input fp32_t a, input fp32_t b);
        longint diff;
        diff = longint'({1'b0, a}) - longint'({1'b0, b});
        return (diff < 0) ? -diff : diff;
    endfunction

    task automatic check_result(input string name, input fp32_t got, input fp32_t expected,
                                input int max_ulp);
        checks++;
        if (ulp_distance(got, expected) > max_ulp) begin
            errors++;
            $display("error: %s got %h expected %h within %0d ulp",
                     name, got, expected, max_ulp);
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("valid_out", valid_out, 1'b0);
        check_result("result", result, '0, 0);
        check_flag("invalid_operation", invalid_operation, 1'b0);
        check_flag("division_by_zero", division_by_zero, 1'b0);
        check_flag("inexact", inexact, 1'b0);
    endtask

    task automatic send_operand(input fp32_t op);
        expect_t e;
        e = expected_response(op);
        @(posedge clk);
        valid_in <= 1'b1;
        operand  <= op;
        e.cycle = neg_count;
        expect_q.push_back(e);
    endtask

    task automatic stop_input();
        @(posedge clk);
        valid_in <= 1'b0;
        operand  <= '0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        stop_input();
        while (expect_q.size() != 0 && waited < 2 * LATENCY) begin
            @(posedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            errors++;
            $display("%0d results never appeared on valid_out", expect_q.size());
            expect_q.delete();
        end
    endtask

    // one expectation per valid_out, sampled away from the driving edge
    always @(negedge clk) begin
        neg_count = neg_count + 1;
        if (!rst && valid_out) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("valid_out rose at cycle %0d with no operand outstanding", neg_count);
            end else begin
                popped = expect_q.pop_front();
                // the operand is sampled one edge after it is driven
                if (neg_count != popped.cycle + LATENCY + 1) begin
                    errors++;
                    $display("result arrived at cycle %0d instead of cycle %0d",
                             neg_count, popped.cycle + LATENCY + 1);
                end
                check_result("result", result, popped.value, popped.approx ? 2 : 0);
                check_flag("invalid_operation", invalid_operation, popped.invalid);
                check_flag("division_by_zero", division_by_zero, popped.div_zero);
                if (popped.check_inexact) begin
                    check_flag("inexact", inexact, popped.inexact);
                end
            end
        end
    end

    task automatic reset_test();
        int waited;
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_idle_outputs();
        end
        send_operand(32'h3F80_0000);
        stop_input();
        // outputs hold their reset values until the first result
        waited = 0;
        @(negedge clk);
        while (!valid_out && waited < 2 * LATENCY) begin
            check_idle_outputs();
            @(negedge clk);
            waited++;
        end
        wait_drain();
    endtask

    task automatic latency_test();
        repeat (8) send_operand(random_normal());
        repeat (3) stop_input();
        repeat (2) send_operand(random_normal());
        stop_input();
        repeat (5) send_operand(random_normal());
        wait_drain();
    endtask

    task automatic normal_operand_test();
        send_operand(32'h3F80_0000);
        send_operand(32'h4080_0000);
        send_operand(32'h3E80_0000);
        repeat (RANDOM_COUNT) send_operand(random_normal());
        wait_drain();
    endtask

    task automatic zero_denormal_test();
        send_operand(32'h0000_0000);
        send_operand(32'h8000_0000);
        send_operand(32'h0001_2345);
        send_operand(32'h007F_FFFF);
        wait_drain();
    endtask

    task automatic nan_test();
        send_operand(32'h7FC1_2345);
        send_operand(32'hFFC0_0001);
        send_operand(32'h7F81_2345);
        send_operand(32'hFF80_0001);
        wait_drain();
    endtask

    task automatic negative_infinity_test();
        send_operand(32'hC080_0000);
        send_operand(32'hBF80_0000);
        send_operand(32'hFF80_0000);
        send_operand(32'h7F80_0000);
        wait_drain();
    endtask

    initial begin
        rst = 1'b1;
        valid_in = 1'b0;
        operand = '0;
        lfsr_state = LFSR_SEED;
        neg_count = 0;
        checks = 0;
        errors = 0;
        reset_test();
        latency_test();
        normal_operand_test();
        zero_denormal_test();
        nan_test();
        negative_infinity_test();
        total_errors = errors + uut.u_checker.failures;
        $display("checks %0d, testbench errors %0d, assertion failures %0d",
                 checks, errors, uut.u_checker.failures);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #((NUM_OPERANDS + 200) * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/isqrt_checker.sv
`timescale 1ns/1ps
`default_nettype none

module isqrt_checker (
    input logic clk,
    input logic rst,
    input logic valid_in,
    input logic valid_out,
    input logic invalid_operation,
    input logic division_by_zero,
    input logic inexact
);

    import isqrt_pkg::*;

    // classify register, mantissa path and output register
    localparam int LATENCY = MANT_LATENCY + 2;

    int unsigned failures = 0;

    flags_idle: assert property (@(posedge clk) disable iff (rst)
        !valid_out |-> !(invalid_operation || division_by_zero || inexact))
    else begin
        failures++;
        $error("flag raised while valid_out is low");
    end

    // a zero operand is a special case and is always exact
    no_inexact_div_zero: assert property (@(posedge clk) disable iff (rst)
        !(inexact && division_by_zero))
    else begin
        failures++;
        $error("inexact and division_by_zero raised together");
    end

    latency_rise: assert property (@(posedge clk) disable iff (rst)
        $past(valid_in, LATENCY) |-> valid_out)
    else begin
        failures++;
        $error("valid_out missing %0d cycles after valid_in", LATENCY);
    end

    latency_fall: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> $past(valid_in, LATENCY))
    else begin
        failures++;
        $error("valid_out raised without a matching valid_in");
    end

endmodule

bind fp_inverse_sqrt isqrt_checker u_checker (
    .clk               (clk),
    .rst               (rst),
    .valid_in          (valid_in),
    .valid_out         (valid_out),
    .invalid_operation (invalid_operation),
    .division_by_zero  (division_by_zero),
    .inexact           (inexact)
);

`default_nettype wire

// File: src/fp_inverse_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module fp_inverse_sqrt (
    input  logic          clk,
    input  logic          rst,
    input  logic          valid_in,
    input  fp_pkg::fp32_t operand,
    output fp_pkg::fp32_t result,
    output logic          valid_out,
    output logic          invalid_operation,
    output logic          division_by_zero,
    output logic          inexact
);

    import fp_pkg::*;
    import isqrt_pkg::*;

    isqrt_side_t cls_side;
    isqrt_side_t mant_side;
    scaled_man_t cls_scaled;
    fp_exp_t     cls_exponent;
    fp_exp_t     new_exponent;
    logic        cls_div_zero;
    logic        dly_div_zero;
    q4_52_t      root_inv;

    // one cycle of classification
    isqrt_classify u_classify (
        .clk        (clk),
        .rst        (rst),
        .valid_in   (valid_in),
        .operand    (operand),
        .side       (cls_side),
        .scaled_man (cls_scaled),
        .exponent   (cls_exponent),
        .div_zero   (cls_div_zero)
    );

    isqrt_exponent #(.DELAY(MANT_LATENCY)) u_exponent (
        .clk          (clk),
        .rst          (rst),
        .exponent     (cls_exponent),
        .div_zero_in  (cls_div_zero),
        .new_exponent (new_exponent),
        .div_zero     (dly_div_zero)
    );

    isqrt_mantissa u_mantissa (
        .clk        (clk),
        .rst        (rst),
        .scaled_man (cls_scaled),
        .side_in    (cls_side),
        .root_inv   (root_inv),
        .side_out   (mant_side)
    );

    // final register stage
    isqrt_round u_round (
        .clk               (clk),
        .rst               (rst),
        .root_inv          (root_inv),
        .side              (mant_side),
        .new_exponent      (new_exponent),
        .div_zero_in       (dly_div_zero),
        .result            (result),
        .valid_out         (valid_out),
        .invalid_operation (invalid_operation),
        .division_by_zero  (division_by_zero),
        .inexact           (inexact)
    );

endmodule

`default_nettype wire

// File: src/isqrt_round.sv
`timescale 1ns/1ps
`default_nettype none

module isqrt_round (
    input  logic                   clk,
    input  logic                   rst,
    input  isqrt_pkg::q4_52_t      root_inv,
    input  isqrt_pkg::isqrt_side_t side,
    input  fp_pkg::fp_exp_t        new_exponent,
    input  logic                   div_zero_in,
    output fp_pkg::fp32_t          result,
    output logic                   valid_out,
    output logic                   invalid_operation,
    output logic                   division_by_zero,
    output logic                   inexact
);

    import fp_pkg::*;

    logic                     int_bit;
    logic                     guard;
    logic                     round_bit;
    logic                     sticky;
    logic                     round_up;
    logic                     grs;
    fp_man_t                  man_trunc;
    fp_man_t                  man_rounded;
    logic [$bits(fp_man_t):0] man_sum;
    fp_exp_t                  exp_norm;
    fp_exp_t                  exp_rounded;

    always_comb begin
        // value is in (0.5,1], only exactly 1.0 reaches the integer bit
        int_bit = root_inv[52];
        if (int_bit) begin
            man_trunc = root_inv[51:29];
            guard     = root_inv[28];
            round_bit = root_inv[27];
            sticky    = |root_inv[26:0];
        end else begin
            man_trunc = root_inv[50:28];
            guard     = root_inv[27];
            round_bit = root_inv[26];
            sticky    = |root_inv[25:0];
        end
        grs = guard | round_bit | sticky;

        // nearest even
        round_up = guard & (round_bit | sticky | man_trunc[0]);
        man_sum  = {1'b0, man_trunc} + round_up;
        exp_norm = new_exponent + int_bit;
        if (man_sum[$bits(fp_man_t)]) begin
            man_rounded = '0;
            exp_rounded = exp_norm + 1'b1;
        end else begin
            man_rounded = man_sum[$bits(fp_man_t)-1:0];
            exp_rounded = exp_norm;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result            <= '0;
            valid_out         <= 1'b0;
            invalid_operation <= 1'b0;
            division_by_zero  <= 1'b0;
            inexact           <= 1'b0;
        end else begin
            valid_out <= side.valid;
            if (!side.valid) begin
                result            <= '0;
                invalid_operation <= 1'b0;
                division_by_zero  <= 1'b0;
                inexact           <= 1'b0;
            end else begin
                invalid_operation <= side.invalid;
                division_by_zero  <= div_zero_in;
                if (side.special_case) begin
                    result  <= side.special_result;
                    inexact <= 1'b0;
                end else begin
                    result  <= {side.sign, exp_rounded, man_rounded};
                    inexact <= grs;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/isqrt_mantissa.sv
`timescale 1ns/1ps
`default_nettype none

module isqrt_mantissa (
    input  logic                   clk,
    input  logic                   rst,
    input  isqrt_pkg::scaled_man_t scaled_man,
    input  isqrt_pkg::isqrt_side_t side_in,
    output isqrt_pkg::q4_52_t      root_inv,
    output isqrt_pkg::isqrt_side_t side_out
);

    import isqrt_pkg::*;

    // integer square root of 2^59 / (2i+1), bit by bit
    function automatic q2_26_t seed_value(input int unsigned idx);
        logic [63:0] num;
        logic [63:0] trial;
        logic [31:0] root;
        num = (64'd1 << SEED_NUM_SHIFT) / 64'(2 * idx + 1);
        root = '0;
        for (int b = 30; b >= 0; b--) begin
            trial = {32'd0, root | (32'd1 << b)};
            if (trial * trial <= num) begin
                root = root | (32'd1 << b);
            end
        end
        // segments below 1.0 are never addressed, just saturate them
        if (root > 32'h0FFF_FFFF) begin
            return '1;
        end
        return root[27:0];
    endfunction

    q2_26_t      seed_rom [SEED_ENTRIES];
    lut_index_t  seed_index;
    q2_26_t      seed;
    q2_26_t      a_scaled;
    q2_26_t      x1;
    q2_26_t      a1;
    q2_26_t      x2;
    isqrt_side_t side_line [MANT_LATENCY];

    for (genvar g = 0; g < SEED_ENTRIES; g++) begin : g_seed
        assign seed_rom[g] = seed_value(g);
    end

    assign seed_index = scaled_man[SEED_INDEX_LSB +: $bits(lut_index_t)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seed     <= '0;
            a_scaled <= '0;
        end else begin
            seed     <= seed_rom[seed_index];
            a_scaled <= {scaled_man, 3'b000};
        end
    end

    newton_step u_step1 (
        .clk   (clk),
        .rst   (rst),
        .x_in  (seed),
        .a_in  (a_scaled),
        .x_out (x1),
        .a_out (a1)
    );

    newton_step u_step2 (
        .clk   (clk),
        .rst   (rst),
        .x_in  (x1),
        .a_in  (a1),
        .x_out (x2),
        .a_out ()
    );

    // place the estimate on the Q4.52 grid the rounder expects
    assign root_inv = {2'b00, x2, 26'd0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MANT_LATENCY; i++) begin
                side_line[i] <= '0;
            end
        end else begin
            side_line[0] <= side_in;
            for (int i = 1; i < MANT_LATENCY; i++) begin
                side_line[i] <= side_line[i-1];
            end
        end
    end

    assign side_out = side_line[MANT_LATENCY-1];

endmodule

`default_nettype wire

// File: src/newton_step.sv
`timescale 1ns/1ps
`default_nettype none

module newton_step (
    input  logic              clk,
    input  logic              rst,
    input  isqrt_pkg::q2_26_t x_in,
    input  isqrt_pkg::q2_26_t a_in,
    output isqrt_pkg::q2_26_t x_out,
    output isqrt_pkg::q2_26_t a_out
);

    import isqrt_pkg::*;

    // square 2 cycles, scale 2, subtract 1
    localparam int X_DELAY = 5;

    q4_52_t w_full;
    q4_52_t y_full;
    q4_52_t x_next_full;
    q2_26_t w;
    q2_26_t y;
    q2_26_t z;
    q2_26_t x_half;
    q2_26_t a_line [NEWTON_LATENCY];
    q2_26_t x_line [X_DELAY];

    // w = x^2
    pipe_mult #(.WIDTH($bits(q2_26_t))) u_square (
        .clk (clk),
        .rst (rst),
        .a   (x_in),
        .b   (x_in),
        .p   (w_full)
    );

    assign w = w_full[Q_TRUNC_LSB +: $bits(q2_26_t)];

    // y = a * w, a taken two cycles late to meet w
    pipe_mult #(.WIDTH($bits(q2_26_t))) u_scale (
        .clk (clk),
        .rst (rst),
        .a   (a_line[1]),
        .b   (w),
        .p   (y_full)
    );

    assign y = y_full[Q_TRUNC_LSB +: $bits(q2_26_t)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            z <= '0;
            for (int i = 0; i < NEWTON_LATENCY; i++) begin
                a_line[i] <= '0;
            end
            for (int i = 0; i < X_DELAY; i++) begin
                x_line[i] <= '0;
            end
        end else begin
            z <= Q_THREE - y;
            a_line[0] <= a_in;
            x_line[0] <= x_in;
            for (int i = 1; i < NEWTON_LATENCY; i++) begin
                a_line[i] <= a_line[i-1];
            end
            for (int i = 1; i < X_DELAY; i++) begin
                x_line[i] <= x_line[i-1];
            end
        end
    end

    // x_next = (x/2) * z
    assign x_half = x_line[X_DELAY-1] >> 1;

    pipe_mult #(.WIDTH($bits(q2_26_t))) u_half (
        .clk (clk),
        .rst (rst),
        .a   (x_half),
        .b   (z),
        .p   (x_next_full)
    );

    assign x_out = x_next_full[Q_TRUNC_LSB +: $bits(q2_26_t)];
    assign a_out = a_line[NEWTON_LATENCY-1];

endmodule

`default_nettype wire

// File: src/isqrt_exponent.sv
`timescale 1ns/1ps
`default_nettype none

module isqrt_exponent #(
    parameter int DELAY = 15
) (
    input  logic            clk,
    input  logic            rst,
    input  fp_pkg::fp_exp_t exponent,
    input  logic            div_zero_in,
    output fp_pkg::fp_exp_t new_exponent,
    output logic            div_zero
);

    import fp_pkg::*;

    logic [8:0] half_sum;
    logic [8:0] biased;
    fp_exp_t    clamped;
    fp_exp_t    exp_line [DELAY];
    logic       dz_line [DELAY];

    always_comb begin
        if (exponent[0]) begin
            half_sum = (FP_EXP_SUM_ODD - {1'b0, exponent}) >> 1;
        end else begin
            half_sum = (FP_EXP_SUM_EVEN - {1'b0, exponent}) >> 1;
        end
        // one less, since the mantissa result sits in (0.5,1]
        biased = half_sum - 9'd1;
        clamped = biased[8] ? '0 : biased[7:0];
    end

    // carry the exponent alongside the mantissa pipeline
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DELAY; i++) begin
                exp_line[i] <= '0;
                dz_line[i]  <= 1'b0;
            end
        end else begin
            exp_line[0] <= clamped;
            dz_line[0]  <= div_zero_in;
            for (int i = 1; i < DELAY; i++) begin
                exp_line[i] <= exp_line[i-1];
                dz_line[i]  <= dz_line[i-1];
            end
        end
    end

    assign new_exponent = exp_line[DELAY-1];
    assign div_zero = dz_line[DELAY-1];

endmodule

`default_nettype wire

// File: src/isqrt_classify.sv
`timescale 1ns/1ps
`default_nettype none

module isqrt_classify (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid_in,
    input  fp_pkg::fp32_t          operand,
    output isqrt_pkg::isqrt_side_t side,
    output isqrt_pkg::scaled_man_t scaled_man,
    output fp_pkg::fp_exp_t        exponent,
    output logic                   div_zero
);

    import fp_pkg::*;
    import isqrt_pkg::*;

    logic        exp_zero;
    logic        exp_ones;
    logic        man_zero;
    logic        is_qnan;
    logic        is_snan;
    logic        is_inf;
    logic        is_tiny;
    fp32_t       quieted;
    isqrt_side_t side_next;
    scaled_man_t scaled_next;

    always_comb begin
        exp_zero = (operand.exponent == '0);
        exp_ones = (operand.exponent == '1);
        man_zero = (operand.mantissa == '0);
        is_qnan  = exp_ones & ~man_zero & operand.mantissa[FP_QNAN_BIT];
        is_snan  = exp_ones & ~man_zero & ~operand.mantissa[FP_QNAN_BIT];
        is_inf   = exp_ones & man_zero;
        // denormals are flushed and treated like zero
        is_tiny  = exp_zero;

        quieted = operand;
        quieted.mantissa[FP_QNAN_BIT] = 1'b1;

        side_next.valid = valid_in;
        side_next.sign = operand.sign;
        side_next.invalid = is_snan;
        side_next.special_case = 1'b1;
        if (is_qnan) begin
            side_next.special_result = operand;
        end else if (is_snan) begin
            side_next.special_result = quieted;
        end else if (operand.sign) begin
            side_next.special_result = FP_DEFAULT_NAN;
        end else if (is_inf) begin
            side_next.special_result = '0;
        end else if (is_tiny) begin
            side_next.special_result = FP_PLUS_INF;
        end else begin
            side_next.special_case = 1'b0;
            side_next.special_result = '0;
        end

        // even biased exponent means odd true exponent, so move one factor of 2 in
        if (operand.exponent[0]) begin
            scaled_next = {2'b01, operand.mantissa};
        end else begin
            scaled_next = {1'b1, operand.mantissa, 1'b0};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            side       <= '0;
            scaled_man <= '0;
            exponent   <= '0;
            div_zero   <= 1'b0;
        end else begin
            side       <= side_next;
            scaled_man <= scaled_next;
            exponent   <= operand.exponent;
            // a negative zero is caught by the negative rule first
            div_zero   <= is_tiny & ~operand.sign;
        end
    end

endmodule

`default_nettype wire

// File: src/pipe_mult.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_mult #(
    parameter int WIDTH = 28
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    output logic [2*WIDTH-1:0] p
);

    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;

    // operands land first, product one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
            p   <= '0;
        end else begin
            a_q <= a;
            b_q <= b;
            p   <= a_q * b_q;
        end
    end

endmodule

`default_nettype wire

// File: src/isqrt_pkg.sv
`default_nettype none

package isqrt_pkg;

    typedef logic [27:0] q2_26_t;
    typedef logic [55:0] q4_52_t;
    // operand mantissa with hidden one, doubled for an even exponent
    typedef logic [24:0] scaled_man_t;
    typedef logic [7:0]  lut_index_t;

    localparam q2_26_t Q_THREE = 28'hC00_0000;
    localparam int Q_TRUNC_LSB = 26;

    // seed table over [1,4), one entry per 1/64 segment
    localparam int SEED_ENTRIES = 256;
    localparam int SEED_INDEX_LSB = 17;
    // segment i has midpoint (2i+1)/128, so seed^2 = 2^59 / (2i+1) in Q2.26
    localparam int SEED_NUM_SHIFT = 59;

    localparam int NEWTON_LATENCY = 7;
    localparam int MANT_LATENCY = 1 + 2 * NEWTON_LATENCY;

    typedef struct packed {
        logic          valid;
        logic          sign;
        logic          special_case;
        fp_pkg::fp32_t special_result;
        logic          invalid;
    } isqrt_side_t;

endpackage

`default_nettype wire

// File: src/fp_pkg.sv
`default_nettype none

package fp_pkg;

    // binary32 field widths
    localparam int FP_EXP_W = 8;
    localparam int FP_MAN_W = 23;
    localparam int FP_BIAS = 127;

    typedef logic [FP_EXP_W-1:0] fp_exp_t;
    typedef logic [FP_MAN_W-1:0] fp_man_t;

    typedef struct packed {
        logic    sign;
        fp_exp_t exponent;
        fp_man_t mantissa;
    } fp32_t;

    // quiet bit of a NaN payload
    localparam int FP_QNAN_BIT = 22;

    localparam fp32_t FP_DEFAULT_NAN = 32'hFFC0_0000;
    localparam fp32_t FP_PLUS_INF = 32'h7F80_0000;

    // three times the bias, plus one for an even biased exponent
    localparam logic [8:0] FP_EXP_SUM_ODD = 9'(3 * FP_BIAS);
    localparam logic [8:0] FP_EXP_SUM_EVEN = 9'(3 * FP_BIAS + 1);

endpackage

`default_nettype wire
